// File: filelist.f
+incdir+include
design/tracker_pkg.sv
design/chroma_stream_if.sv
design/ycrcb_convert.sv
design/centroid_divider.sv
design/chroma_tracker.sv
design/marker_overlay.sv
design/color_tracker_top.sv
tb/tb_color_tracker.sv

// File: Bender.yml
package:
  name: color_tracker

export_include_dirs:
  - include

sources:
  - files:
      - design/tracker_pkg.sv
      - design/chroma_stream_if.sv
      - design/ycrcb_convert.sv
      - design/centroid_divider.sv
      - design/chroma_tracker.sv
      - design/marker_overlay.sv
      - design/color_tracker_top.sv
  - target: test
    files:
      - tb/tb_color_tracker.sv

// File: tb/tb_color_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tracker_params.svh"

module tb_color_tracker;

  localparam int CLK_PERIOD     = 40;
  localparam int UPDATE_TIMEOUT = 80;
  // test lengths in cycles, frame tests include the full pulse timeout
  localparam int RESET_LEN   = 6;
  localparam int PASS_LEN    = 20;
  localparam int CR_LEN      = 95;
  localparam int DUAL_LEN    = 100;
  localparam int OVERLAY_LEN = 20;
  localparam int EMPTY_LEN   = 95;
  localparam int TEST_CYCLES = RESET_LEN + PASS_LEN + CR_LEN + DUAL_LEN + OVERLAY_LEN + EMPTY_LEN;
  localparam longint WATCHDOG_NS = longint'(TEST_CYCLES) * 2 * CLK_PERIOD;

  logic                   clk_pixel;
  logic                   sys_rst_pixel;
  logic                   pixel_valid_i;
  tracker_pkg::hcount_t   hcount_i;
  tracker_pkg::vcount_t   vcount_i;
  tracker_pkg::rgb565_t   pixel_i;
  logic                   new_frame_i;
  logic                   pixel_valid_o;
  tracker_pkg::rgb888_t   pixel_o;
  tracker_pkg::hcount_t   centroid_cr_x_o;
  tracker_pkg::vcount_t   centroid_cr_y_o;
  tracker_pkg::hcount_t   centroid_cb_x_o;
  tracker_pkg::vcount_t   centroid_cb_y_o;
  logic                   centroid_update_o;

  int check_count;
  int error_count;

  // pixels of the next burst or frame
  tracker_pkg::hcount_t hq[$];
  tracker_pkg::vcount_t vq[$];
  tracker_pkg::rgb565_t pq[$];

  // model of the held centroids and of which channels have reported
  tracker_pkg::hcount_t exp_cr_x;
  tracker_pkg::vcount_t exp_cr_y;
  tracker_pkg::hcount_t exp_cb_x;
  tracker_pkg::vcount_t exp_cb_y;
  logic                 cr_seen;
  logic                 cb_seen;

  color_tracker_top uut (
    .clk_pixel         (clk_pixel),
    .sys_rst_pixel     (sys_rst_pixel),
    .pixel_valid_i     (pixel_valid_i),
    .hcount_i          (hcount_i),
    .vcount_i          (vcount_i),
    .pixel_i           (pixel_i),
    .new_frame_i       (new_frame_i),
    .pixel_valid_o     (pixel_valid_o),
    .pixel_o           (pixel_o),
    .centroid_cr_x_o   (centroid_cr_x_o),
    .centroid_cr_y_o   (centroid_cr_y_o),
    .centroid_cb_x_o   (centroid_cb_x_o),
    .centroid_cb_y_o   (centroid_cb_y_o),
    .centroid_update_o (centroid_update_o)
  );

  initial
  begin
    clk_pixel = 1'b0;
    forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
  end

  // conversion rule: zero padded 565 expansion, scaled chroma offset by 128
  task automatic predict_pixel(input tracker_pkg::rgb565_t p, output tracker_pkg::rgb888_t rgb,
                               output tracker_pkg::chroma_t cr, output tracker_pkg::chroma_t cb);
    int r;
    int g;
    int b;
    r = {p[15:11], 3'b000};
    g = {p[10:5], 2'b00};
    b = {p[4:0], 3'b000};
    rgb.r = 8'(r);
    rgb.g = 8'(g);
    rgb.b = 8'(b);
    cr = tracker_pkg::chroma_t'(((112 * r - 94 * g - 18 * b) >>> 8) + 128);
    cb = tracker_pkg::chroma_t'(((112 * b - 38 * r - 74 * g) >>> 8) + 128);
  endtask

  function automatic bit in_window(input tracker_pkg::chroma_t c);
    return (c >= `CHROMA_LO) && (c <= `CHROMA_HI);
  endfunction

  // rectangle spanned by the two modelled centres
  task automatic model_box(output tracker_pkg::hcount_t x_lo, output tracker_pkg::hcount_t x_hi,
                           output tracker_pkg::vcount_t y_lo, output tracker_pkg::vcount_t y_hi);
    x_lo = (exp_cr_x < exp_cb_x) ? exp_cr_x : exp_cb_x;
    x_hi = (exp_cr_x < exp_cb_x) ? exp_cb_x : exp_cr_x;
    y_lo = (exp_cr_y < exp_cb_y) ? exp_cr_y : exp_cb_y;
    y_hi = (exp_cr_y < exp_cb_y) ? exp_cb_y : exp_cr_y;
  endtask

  // overlay output expected for one pixel
  task automatic predict_output(input tracker_pkg::hcount_t h, input tracker_pkg::vcount_t v,
                                input tracker_pkg::rgb565_t p, output tracker_pkg::rgb888_t out);
    tracker_pkg::chroma_t cr;
    tracker_pkg::chroma_t cb;
    tracker_pkg::hcount_t x_lo;
    tracker_pkg::hcount_t x_hi;
    tracker_pkg::vcount_t y_lo;
    tracker_pkg::vcount_t y_hi;
    predict_pixel(p, out, cr, cb);
    model_box(x_lo, x_hi, y_lo, y_hi);
    if (cr_seen && cb_seen && h >= x_lo && h <= x_hi && v >= y_lo && v <= y_hi)
      out = tracker_pkg::rgb888_t'(`MARK_COLOR);
  endtask

  task automatic check_rgb(input string name, input tracker_pkg::rgb888_t expected,
                           input tracker_pkg::rgb888_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %s: expected %06h, actual %06h", name, expected, actual);
    end
  endtask

  task automatic check_coord_h(input string name, input tracker_pkg::hcount_t expected,
                               input tracker_pkg::hcount_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %s: expected x %0d, actual x %0d", name, expected, actual);
    end
  endtask

  task automatic check_coord_v(input string name, input tracker_pkg::vcount_t expected,
                               input tracker_pkg::vcount_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %s: expected y %0d, actual y %0d", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_centroids(input string name);
    check_coord_h(name, exp_cr_x, centroid_cr_x_o);
    check_coord_v(name, exp_cr_y, centroid_cr_y_o);
    check_coord_h(name, exp_cb_x, centroid_cb_x_o);
    check_coord_v(name, exp_cb_y, centroid_cb_y_o);
  endtask

  task automatic finish_test(input string name, input int first_err);
    $display("%-16s done, %0d error(s)", name, error_count - first_err);
  endtask

  // inputs change 2 ns after the edge, well clear of sampling
  task automatic drive_cycle(input logic valid, input tracker_pkg::hcount_t h,
                             input tracker_pkg::vcount_t v, input tracker_pkg::rgb565_t p);
    @(posedge clk_pixel);
    #2;
    pixel_valid_i = valid;
    hcount_i      = h;
    vcount_i      = v;
    pixel_i       = p;
  endtask

  task automatic add_pixel(input tracker_pkg::hcount_t h, input tracker_pkg::vcount_t v,
                           input tracker_pkg::rgb565_t p);
    hq.push_back(h);
    vq.push_back(v);
    pq.push_back(p);
  endtask

  // random colour that falls outside both chroma windows
  task automatic add_background(input tracker_pkg::hcount_t h, input tracker_pkg::vcount_t v);
    tracker_pkg::rgb565_t p;
    tracker_pkg::rgb888_t rgb;
    tracker_pkg::chroma_t cr;
    tracker_pkg::chroma_t cb;
    do
    begin
      p = tracker_pkg::rgb565_t'($urandom);
      predict_pixel(p, rgb, cr, cb);
    end
    while (in_window(cr) || in_window(cb));
    add_pixel(h, v, p);
  endtask

  task automatic clear_queues();
    hq.delete();
    vq.delete();
    pq.delete();
  endtask

  // sums of passing pixels give floor means for each channel
  task automatic model_frame(output bit expect_update);
    tracker_pkg::rgb888_t rgb;
    tracker_pkg::chroma_t cr;
    tracker_pkg::chroma_t cb;
    longint cr_sx = 0;
    longint cr_sy = 0;
    longint cr_n  = 0;
    longint cb_sx = 0;
    longint cb_sy = 0;
    longint cb_n  = 0;
    for (int i = 0; i < pq.size(); i++)
    begin
      predict_pixel(pq[i], rgb, cr, cb);
      if (in_window(cr))
      begin
        cr_sx += hq[i];
        cr_sy += vq[i];
        cr_n++;
      end
      if (in_window(cb))
      begin
        cb_sx += hq[i];
        cb_sy += vq[i];
        cb_n++;
      end
    end
    if (cr_n > 0)
    begin
      exp_cr_x = tracker_pkg::hcount_t'(cr_sx / cr_n);
      exp_cr_y = tracker_pkg::vcount_t'(cr_sy / cr_n);
      cr_seen  = 1'b1;
    end
    if (cb_n > 0)
    begin
      exp_cb_x = tracker_pkg::hcount_t'(cb_sx / cb_n);
      exp_cb_y = tracker_pkg::vcount_t'(cb_sy / cb_n);
      cb_seen  = 1'b1;
    end
    expect_update = (cr_n > 0) || (cb_n > 0);
  endtask

  // back to back pixels, one gap, then the strobe on its own
  task automatic send_frame();
    for (int i = 0; i < pq.size(); i++)
      drive_cycle(1'b1, hq[i], vq[i], pq[i]);
    drive_cycle(1'b0, '0, '0, '0);
    @(posedge clk_pixel);
    #2;
    new_frame_i = 1'b1;
    @(posedge clk_pixel);
    #2;
    new_frame_i = 1'b0;
  endtask

  task automatic wait_update(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < UPDATE_TIMEOUT; i++)
    begin
      @(negedge clk_pixel);
      if (centroid_update_o)
      begin
        seen = 1'b1;
        break;
      end
    end
  endtask

  // the burst in the queues must come out 4 cycles later, in order
  task automatic stream_and_check(input string name);
    tracker_pkg::rgb888_t exp_q[$];
    tracker_pkg::rgb888_t e;
    int   n;
    int   first_err;
    logic exp_valid;
    n = pq.size();
    first_err = error_count;
    for (int i = 0; i < n; i++)
    begin
      predict_output(hq[i], vq[i], pq[i], e);
      exp_q.push_back(e);
    end
    for (int c = 0; c < n + 6; c++)
    begin
      if (c < n)
        drive_cycle(1'b1, hq[c], vq[c], pq[c]);
      else
        drive_cycle(1'b0, '0, '0, '0);
      @(negedge clk_pixel);
      exp_valid = (c >= 4) && (c - 4 < n);
      check_bit(name, exp_valid, pixel_valid_o);
      if (exp_valid)
        check_rgb(name, exp_q[c - 4], pixel_o);
    end
    clear_queues();
    finish_test(name, first_err);
  endtask

  task automatic frame_test(input string name);
    bit expect_update;
    bit seen;
    int first_err;
    first_err = error_count;
    model_frame(expect_update);
    send_frame();
    clear_queues();
    wait_update(seen);
    check_count++;
    if (expect_update && !seen)
    begin
      error_count++;
      $display("%s: no centroid update within %0d cycles of the frame strobe",
               name, UPDATE_TIMEOUT);
    end
    else if (!expect_update && seen)
    begin
      error_count++;
      $display("%s: centroid update pulsed although no pixel passed a threshold", name);
    end
    check_centroids(name);
    finish_test(name, first_err);
  endtask

  task automatic test_reset();
    int first_err;
    first_err = error_count;
    @(negedge clk_pixel);
    check_bit("reset", 1'b0, pixel_valid_o);
    check_bit("reset", 1'b0, centroid_update_o);
    check_centroids("reset");
    finish_test("reset", first_err);
  endtask

  // the first pixel sits on the zeroed held centres, so no box may show yet
  task automatic test_pass_through();
    for (int i = 0; i < 12; i++)
      add_background(tracker_pkg::hcount_t'(i), tracker_pkg::vcount_t'(0));
    stream_and_check("pass_through");
  endtask

  // red blobs pass Cr only
  task automatic test_cr_tracking();
    add_pixel(100, 50, 16'hF800);
    add_background(101, 50);
    add_pixel(103, 52, 16'hE000);
    add_background(104, 52);
    add_pixel(110, 57, 16'hF800);
    add_background(111, 57);
    frame_test("cr_tracking");
  endtask

  // red and blue regions in the same frame
  task automatic test_dual_tracking();
    add_pixel(200, 120, 16'hF800);
    add_pixel(204, 121, 16'hE000);
    add_background(205, 121);
    add_pixel(201, 125, 16'hF800);
    add_pixel(207, 126, 16'hF800);
    add_background(300, 200);
    add_pixel(400, 300, 16'h001F);
    add_pixel(405, 302, 16'h001C);
    add_background(406, 302);
    add_pixel(409, 307, 16'h001F);
    frame_test("dual_tracking");
  endtask

  // corners and centre inside, one step past each edge outside
  task automatic test_overlay();
    tracker_pkg::hcount_t x_lo;
    tracker_pkg::hcount_t x_hi;
    tracker_pkg::vcount_t y_lo;
    tracker_pkg::vcount_t y_hi;
    model_box(x_lo, x_hi, y_lo, y_hi);
    add_background(x_lo, y_lo);
    add_background(x_hi, y_hi);
    add_background(x_lo, y_hi);
    add_background(x_hi, y_lo);
    add_background((x_lo + x_hi) / 2, (y_lo + y_hi) / 2);
    add_background(x_lo - 1'b1, y_lo);
    add_background(x_hi + 1'b1, y_hi);
    add_background(x_lo, y_lo - 1'b1);
    add_background(x_hi, y_hi + 1'b1);
    stream_and_check("overlay");
  endtask

  task automatic test_empty_frame();
    for (int i = 0; i < 6; i++)
      add_background(tracker_pkg::hcount_t'(600 + i), tracker_pkg::vcount_t'(400));
    frame_test("empty_frame");
  endtask

  initial
  begin
    void'($urandom(32'hdbea9ac1));
    check_count   = 0;
    error_count   = 0;
    sys_rst_pixel = 1'b1;
    pixel_valid_i = 1'b0;
    hcount_i      = '0;
    vcount_i      = '0;
    pixel_i       = '0;
    new_frame_i   = 1'b0;
    exp_cr_x      = '0;
    exp_cr_y      = '0;
    exp_cb_x      = '0;
    exp_cb_y      = '0;
    cr_seen       = 1'b0;
    cb_seen       = 1'b0;
    repeat (5) @(posedge clk_pixel);
    #2;
    sys_rst_pixel = 1'b0;
    test_reset();
    test_pass_through();
    test_cr_tracking();
    test_dual_tracking();
    test_overlay();
    test_empty_frame();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  // bounds the run at twice the expected length
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/color_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module color_tracker_top
  (
    input wire                       clk_pixel,
    input wire                       sys_rst_pixel,
    input wire                       pixel_valid_i,
    input wire tracker_pkg::hcount_t hcount_i,
    input wire tracker_pkg::vcount_t vcount_i,
    input wire tracker_pkg::rgb565_t pixel_i,
    input wire                       new_frame_i,
    output logic                     pixel_valid_o,
    output tracker_pkg::rgb888_t     pixel_o,
    output tracker_pkg::hcount_t     centroid_cr_x_o,
    output tracker_pkg::vcount_t     centroid_cr_y_o,
    output tracker_pkg::hcount_t     centroid_cb_x_o,
    output tracker_pkg::vcount_t     centroid_cb_y_o,
    output logic                     centroid_update_o
  );

  // converted stream shared by both trackers and the overlay
  chroma_stream_if stream ();

  tracker_pkg::centroid_t cr_centroid;
  tracker_pkg::centroid_t cb_centroid;
  tracker_pkg::centroid_t cr_pos;
  tracker_pkg::centroid_t cb_pos;

  ycrcb_convert convert (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .pixel_valid_i (pixel_valid_i),
    .hcount_i      (hcount_i),
    .vcount_i      (vcount_i),
    .pixel_i       (pixel_i),
    .stream_o      (stream)
  );

  // red target
  chroma_tracker #(.CHANNEL(tracker_pkg::CR)) track_cr (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .stream_i      (stream),
    .new_frame_i   (new_frame_i),
    .centroid_o    (cr_centroid)
  );

  // blue target
  chroma_tracker #(.CHANNEL(tracker_pkg::CB)) track_cb (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .stream_i      (stream),
    .new_frame_i   (new_frame_i),
    .centroid_o    (cb_centroid)
  );

  marker_overlay overlay (
    .clk_pixel         (clk_pixel),
    .sys_rst_pixel     (sys_rst_pixel),
    .stream_i          (stream),
    .cr_centroid_i     (cr_centroid),
    .cb_centroid_i     (cb_centroid),
    .pixel_valid_o     (pixel_valid_o),
    .pixel_o           (pixel_o),
    .cr_pos_o          (cr_pos),
    .cb_pos_o          (cb_pos),
    .centroid_update_o (centroid_update_o)
  );

  // held positions out to the pins
  assign centroid_cr_x_o = cr_pos.x;
  assign centroid_cr_y_o = cr_pos.y;
  assign centroid_cb_x_o = cb_pos.x;
  assign centroid_cb_y_o = cb_pos.y;

endmodule

`default_nettype wire

// File: design/marker_overlay.sv
`timescale 1ns/1ps
`default_nettype none

`include "tracker_params.svh"

module marker_overlay
  (
    input wire                         clk_pixel,
    input wire                         sys_rst_pixel,
    chroma_stream_if.sink              stream_i,
    input wire tracker_pkg::centroid_t cr_centroid_i,
    input wire tracker_pkg::centroid_t cb_centroid_i,
    output logic                       pixel_valid_o,
    output tracker_pkg::rgb888_t       pixel_o,
    output tracker_pkg::centroid_t     cr_pos_o,
    output tracker_pkg::centroid_t     cb_pos_o,
    output logic                       centroid_update_o
  );

  // box corners sorted per axis
  tracker_pkg::hcount_t x_lo;
  tracker_pkg::hcount_t x_hi;
  tracker_pkg::vcount_t y_lo;
  tracker_pkg::vcount_t y_hi;
  logic                 in_box;

  // held centroids, the stored valid bit says the channel has reported
  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      cr_pos_o          <= '0;
      cb_pos_o          <= '0;
      centroid_update_o <= 1'b0;
    end
    else
    begin
      if (cr_centroid_i.valid)
        cr_pos_o <= cr_centroid_i;
      if (cb_centroid_i.valid)
        cb_pos_o <= cb_centroid_i;
      centroid_update_o <= cr_centroid_i.valid || cb_centroid_i.valid;
    end
  end

  always_comb
  begin
    // either centre may be the upper left corner
    x_lo = (cr_pos_o.x < cb_pos_o.x) ? cr_pos_o.x : cb_pos_o.x;
    x_hi = (cr_pos_o.x < cb_pos_o.x) ? cb_pos_o.x : cr_pos_o.x;
    y_lo = (cr_pos_o.y < cb_pos_o.y) ? cr_pos_o.y : cb_pos_o.y;
    y_hi = (cr_pos_o.y < cb_pos_o.y) ? cb_pos_o.y : cr_pos_o.y;
    // filled box, edges included, only once both channels exist
    in_box = cr_pos_o.valid && cb_pos_o.valid
             && (stream_i.hcount >= x_lo) && (stream_i.hcount <= x_hi)
             && (stream_i.vcount >= y_lo) && (stream_i.vcount <= y_hi);
  end

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      pixel_valid_o <= 1'b0;
    end
    else
    begin
      pixel_valid_o <= stream_i.valid;
    end
  end

  // camera pixel unless it falls in the box
  always_ff @(posedge clk_pixel)
  begin
    pixel_o <= in_box ? tracker_pkg::rgb888_t'(`MARK_COLOR) : stream_i.rgb;
  end

endmodule

`default_nettype wire

// File: design/chroma_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tracker_params.svh"

module chroma_tracker
  #(
    parameter tracker_pkg::chroma_sel_e CHANNEL = tracker_pkg::CR
  )
  (
    input wire                      clk_pixel,
    input wire                      sys_rst_pixel,
    chroma_stream_if.sink           stream_i,
    input wire                      new_frame_i,
    output tracker_pkg::centroid_t  centroid_o
  );

  localparam int LAT = `CONV_LATENCY;

  tracker_pkg::chroma_t chroma;
  logic                 hit;

  // strobe delayed to the stream so in-flight pixels land in their own frame
  logic [LAT-1:0] frame_d;
  logic           frame_end;

  tracker_pkg::sum_t   sum_x;
  tracker_pkg::sum_t   sum_y;
  tracker_pkg::count_t count;

  logic start;
  logic busy_x;
  logic busy_y;
  logic done_x;
  logic done_y;
  logic report;

  tracker_pkg::hcount_t mean_x;
  tracker_pkg::vcount_t mean_y;

  // pick the channel and test the window, bounds inclusive
  assign chroma = (CHANNEL == tracker_pkg::CR) ? stream_i.cr : stream_i.cb;
  assign hit    = stream_i.valid && (chroma >= `CHROMA_LO) && (chroma <= `CHROMA_HI);

  assign frame_end = frame_d[LAT-1];

  // empty frames and frames that arrive mid division are skipped
  assign start = frame_end && (count != '0) && !busy_x && !busy_y;

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      frame_d <= '0;
    end
    else
    begin
      frame_d <= {frame_d[LAT-2:0], new_frame_i};
    end
  end

  // accumulators restart on every frame boundary
  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel || frame_end)
    begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end
    else if (hit)
    begin
      sum_x <= sum_x + stream_i.hcount;
      sum_y <= sum_y + stream_i.vcount;
      count <= count + 1'b1;
    end
  end

  centroid_divider #(
    .quot_t(tracker_pkg::hcount_t)
  ) div_x (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start),
    .dividend_i    (sum_x),
    .divisor_i     (count),
    .quotient_o    (mean_x),
    .busy_o        (busy_x),
    .done_o        (done_x)
  );

  centroid_divider #(
    .quot_t(tracker_pkg::vcount_t)
  ) div_y (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start),
    .dividend_i    (sum_y),
    .divisor_i     (count),
    .quotient_o    (mean_y),
    .busy_o        (busy_y),
    .done_o        (done_y)
  );

  // both dividers start together and run the same number of steps
  assign report = done_x && done_y;

  // quotients hold until the next start, so the struct is stable at the pulse
  assign centroid_o = '{x: mean_x, y: mean_y, valid: report};

endmodule

`default_nettype wire

// File: design/centroid_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "tracker_params.svh"

module centroid_divider
  #(
    parameter type quot_t = tracker_pkg::hcount_t
  )
  (
    input wire                      clk_pixel,
    input wire                      sys_rst_pixel,
    input wire                      start_i,
    input wire tracker_pkg::sum_t   dividend_i,
    input wire tracker_pkg::count_t divisor_i,
    output quot_t                   quotient_o,
    output logic                    busy_o,
    output logic                    done_o
  );

  localparam int SW     = `SUM_WIDTH;
  localparam int CW     = `CNT_WIDTH;
  localparam int STEP_W = $clog2(SW);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(SW - 1);

  // dividend shifts out the top while quotient bits shift in at the bottom
  tracker_pkg::sum_t   quo;
  tracker_pkg::count_t rem;
  tracker_pkg::count_t div;
  logic [STEP_W-1:0]   step;

  logic [CW:0] trial;
  logic [CW:0] diff;
  logic        fits;

  // restoring step, remainder stays below the divisor
  always_comb
  begin
    trial = {rem, quo[SW-1]};
    diff  = trial - {1'b0, div};
    fits  = trial >= {1'b0, div};
  end

  // sequencing, one quotient bit per cycle
  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      step   <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        busy_o <= 1'b1;
        step   <= '0;
      end
      else if (busy_o)
      begin
        step <= step + 1'b1;
        if (step == LAST_STEP)
        begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (start_i)
    begin
      quo <= dividend_i;
      rem <= '0;
      div <= divisor_i;
    end
    else if (busy_o)
    begin
      quo <= {quo[SW-2:0], fits};
      rem <= fits ? diff[CW-1:0] : trial[CW-1:0];
    end
  end

  // a mean never exceeds the largest coordinate, low bits are enough
  assign quotient_o = quot_t'(quo);

endmodule

`default_nettype wire

// File: design/ycrcb_convert.sv
`timescale 1ns/1ps
`default_nettype none

`include "tracker_params.svh"

module ycrcb_convert
  (
    input wire                       clk_pixel,
    input wire                       sys_rst_pixel,
    input wire                       pixel_valid_i,
    input wire tracker_pkg::hcount_t hcount_i,
    input wire tracker_pkg::vcount_t vcount_i,
    input wire tracker_pkg::rgb565_t pixel_i,
    chroma_stream_if.source          stream_o
  );

  localparam int DEPTH = `CONV_LATENCY;

  // side band delay line, one entry per arithmetic stage
  logic                 valid_d  [DEPTH];
  tracker_pkg::hcount_t hcount_d [DEPTH];
  tracker_pkg::vcount_t vcount_d [DEPTH];

  // colour follows the arithmetic stage by stage
  tracker_pkg::rgb888_t rgb_s1;
  tracker_pkg::rgb888_t rgb_s2;
  tracker_pkg::rgb888_t rgb_s3;

  // weighted sums, worst case magnitude 112*255 fits in 18 bits signed
  logic signed [17:0] cr_acc;
  logic signed [17:0] cb_acc;
  tracker_pkg::chroma_t cr_s3;
  tracker_pkg::chroma_t cb_s3;

  // valid is the only control bit here
  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        valid_d[i] <= 1'b0;
      end
    end
    else
    begin
      valid_d[0] <= pixel_valid_i;
      for (int i = 1; i < DEPTH; i++)
      begin
        valid_d[i] <= valid_d[i-1];
      end
    end
  end

  // coordinates ride along with the pixel
  always_ff @(posedge clk_pixel)
  begin
    hcount_d[0] <= hcount_i;
    vcount_d[0] <= vcount_i;
    for (int i = 1; i < DEPTH; i++)
    begin
      hcount_d[i] <= hcount_d[i-1];
      vcount_d[i] <= vcount_d[i-1];
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    // stage 1: widen 565 by padding the low bits with zeros
    rgb_s1.r <= {pixel_i[15:11], 3'b000};
    rgb_s1.g <= {pixel_i[10:5], 2'b00};
    rgb_s1.b <= {pixel_i[4:0], 3'b000};
    // stage 2: weighted sums, channels treated as unsigned
    cr_acc <= 18'sd112 * $signed({1'b0, rgb_s1.r})
              - 18'sd94 * $signed({1'b0, rgb_s1.g})
              - 18'sd18 * $signed({1'b0, rgb_s1.b});
    cb_acc <= 18'sd112 * $signed({1'b0, rgb_s1.b})
              - 18'sd38 * $signed({1'b0, rgb_s1.r})
              - 18'sd74 * $signed({1'b0, rgb_s1.g});
    rgb_s2 <= rgb_s1;
    // stage 3: scale down, keep 8 bits and move zero to 128
    cr_s3  <= tracker_pkg::chroma_t'(cr_acc >>> 8) + 8'd128;
    cb_s3  <= tracker_pkg::chroma_t'(cb_acc >>> 8) + 8'd128;
    rgb_s3 <= rgb_s2;
  end

  assign stream_o.valid  = valid_d[DEPTH-1];
  assign stream_o.hcount = hcount_d[DEPTH-1];
  assign stream_o.vcount = vcount_d[DEPTH-1];
  assign stream_o.rgb    = rgb_s3;
  assign stream_o.cr     = cr_s3;
  assign stream_o.cb     = cb_s3;

endmodule

`default_nettype wire

// File: design/chroma_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface chroma_stream_if;

  // one converted pixel per cycle while valid is high
  logic                 valid;
  tracker_pkg::hcount_t hcount;
  tracker_pkg::vcount_t vcount;
  tracker_pkg::rgb888_t rgb;
  tracker_pkg::chroma_t cr;
  tracker_pkg::chroma_t cb;

  // converter side
  modport source (
    output valid, hcount, vcount, rgb, cr, cb
  );

  // trackers and overlay
  modport sink (
    input valid, hcount, vcount, rgb, cr, cb
  );

endinterface

`default_nettype wire

// File: design/tracker_pkg.sv
`default_nettype none

`include "tracker_params.svh"

package tracker_pkg;

  // screen coordinates as produced by the pixel source
  typedef logic [`H_WIDTH-1:0] hcount_t;
  typedef logic [`V_WIDTH-1:0] vcount_t;

  // raw camera pixel, 5 bits red, 6 green, 5 blue
  typedef logic [15:0] rgb565_t;

  // expanded pixel, red in the top byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Cr or Cb with the signed value offset by 128
  typedef logic [7:0] chroma_t;

  // which chroma channel a tracker watches
  typedef enum logic {
    CR = 1'b0,
    CB = 1'b1
  } chroma_sel_e;

  // centre of mass, valid marks a fresh result
  typedef struct packed {
    hcount_t x;
    vcount_t y;
    logic    valid;
  } centroid_t;

  // per frame accumulators
  typedef logic [`SUM_WIDTH-1:0] sum_t;
  typedef logic [`CNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// File: include/tracker_params.svh
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// horizontal count width, enough for a 1280 pixel line
`define H_WIDTH 11

// vertical count width, 720 lines
`define V_WIDTH 10

// coordinate sum width
// a full 1280x720 frame of hcount values stays below 2^31
`define SUM_WIDTH 32

// passing pixel count, a full frame is 921600 pixels
`define CNT_WIDTH 21

// inclusive chroma window, same bounds for Cr and Cb
`define CHROMA_LO 8'hA0
`define CHROMA_HI 8'hF0

// cycles from a pixel entering the converter to its converted value
`define CONV_LATENCY 3

// box colour drawn over the camera pixel
`define MARK_COLOR 24'hFFFFFF

`endif
